//--- hw/frontend_pkg.sv
package frontend_pkg;

    // counter table geometry
    // pc bits [PC_INDEX_WIDTH+2:3] select one counter per 8-byte bundle
    localparam int PC_INDEX_WIDTH = 8;
    localparam int COUNTER_ENTRIES = 1 << PC_INDEX_WIDTH;

    // fetch queue geometry
    // depth must stay a power of two, pointers wrap naturally
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    // one extra bit so a full queue is distinct from an empty one
    localparam int QUEUE_CNT_WIDTH = QUEUE_PTR_WIDTH + 1;

    // unconditional jumps, matched on inst[31:27]
    localparam logic [4:0] OP_UNCOND_A = 5'b01010;
    localparam logic [4:0] OP_UNCOND_B = 5'b01001;

    // pc-relative conditional branches
    // first on inst[31:27], second on inst[31:28]
    localparam logic [4:0] OP_PCREL_A = 5'b01011;
    localparam logic [3:0] OP_PCREL_B = 4'b0110;

    // register-indirect jump, matched on inst[31:26]
    // note this also hits OP_UNCOND_B on the upper five bits
    localparam logic [5:0] OP_INDIRECT = 6'b010011;

    // 2-bit saturating counter states
    localparam logic [1:0] CTR_MIN = 2'b00;
    localparam logic [1:0] CTR_WEAK_NT = 2'b01;
    localparam logic [1:0] CTR_MAX = 2'b11;

    // branch class, encodings as used by the predecoder
    typedef enum logic [1:0] {
        NONE     = 2'b00,
        UNCOND   = 2'b01,
        PCREL    = 2'b10,
        INDIRECT = 2'b11
    } btype_e;

    // one entry of the fetch queue
    // inst0 sits at pc, inst1 at pc+4
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
    } fetch_bundle_t;

    // predecoder result for the head bundle
    typedef struct packed {
        // slot 1 in the upper position
        btype_e [1:0]              slot_btype;
        btype_e                    bundle_btype;
        logic [PC_INDEX_WIDTH-1:0] index;
    } predecode_t;

    // training info from the branch unit
    typedef struct packed {
        logic [PC_INDEX_WIDTH-1:0] index;
        logic                      taken;
    } resolve_t;

endpackage

//--- hw/fetch_queue.sv
module fetch_queue (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  frontend_pkg::fetch_bundle_t push_bundle,
    input  logic                       pop,
    output frontend_pkg::fetch_bundle_t head_bundle,
    output logic                       head_valid,
    output logic                       full
);
    import frontend_pkg::*;

    // bundle storage, no reset on payload
    fetch_bundle_t mem [QUEUE_DEPTH];

    // write and read pointers
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;

    // number of stored bundles, 0 .. QUEUE_DEPTH
    logic [QUEUE_CNT_WIDTH-1:0] count;

    // qualified strobes
    logic push_en;
    logic pop_en;

    // status levels straight off the count
    assign head_valid = (count != '0);
    assign full = (count == QUEUE_CNT_WIDTH'(QUEUE_DEPTH));

    // a push while full is dropped so the stored bundles survive
    assign push_en = push && !full;
    // a pop on an empty queue is ignored
    assign pop_en = pop && head_valid;

    // head is read directly from the array
    assign head_bundle = mem[rd_ptr];

    // payload write
    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[wr_ptr] <= push_bundle;
        end
    end

    // pointer and occupancy update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push_en, pop_en})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // fetch stage must respect back-pressure
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> !full
    ) else $error("fetch_queue: push while full");

    // consumer must only pop a valid head
    a_no_pop_when_empty : assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> head_valid
    ) else $error("fetch_queue: pop while empty");

endmodule

//--- hw/fifo_predecoder.sv
module fifo_predecoder (
    input  frontend_pkg::fetch_bundle_t head_bundle,
    output frontend_pkg::predecode_t    predecode
);
    import frontend_pkg::*;

    // per-slot classes
    btype_e inst0_btype;
    btype_e inst1_btype;
    // combined class for the bundle
    btype_e bundle_btype;
    // counter table index
    logic [PC_INDEX_WIDTH-1:0] inst_index;

    // classify one instruction word
    // indirect is tested first, its opcode lies inside OP_UNCOND_B
    function automatic btype_e classify_slot(input logic [31:0] inst);
        btype_e cls;
        if (inst[31:26] == OP_INDIRECT) begin
            cls = INDIRECT;
        end else if ((inst[31:27] == OP_UNCOND_A) || (inst[31:27] == OP_UNCOND_B)) begin
            cls = UNCOND;
        end else if ((inst[31:27] == OP_PCREL_A) || (inst[31:28] == OP_PCREL_B)) begin
            cls = PCREL;
        end else begin
            cls = NONE;
        end
        return cls;
    endfunction

    // same decoder for both slots
    assign inst0_btype = classify_slot(head_bundle.inst0);
    assign inst1_btype = classify_slot(head_bundle.inst1);

    // bundle class
    always_comb begin
        if (inst1_btype != NONE) begin
            // slot 1 wins whenever it branches
            bundle_btype = inst1_btype;
        end else if (head_bundle.pc[2]) begin
            // pc at upper word, slot 0 not part of this fetch
            bundle_btype = NONE;
        end else if (inst0_btype == INDIRECT) begin
            bundle_btype = INDIRECT;
        end else begin
            // other slot 0 branches are not reported
            bundle_btype = NONE;
        end
    end

    // bits 2:0 are the offset inside the bundle
    assign inst_index = head_bundle.pc[PC_INDEX_WIDTH+2:3];

    // pack the result
    assign predecode.slot_btype[1] = inst1_btype;
    assign predecode.slot_btype[0] = inst0_btype;
    assign predecode.bundle_btype = bundle_btype;
    assign predecode.index = inst_index;

endmodule

//--- hw/branch_counter_table.sv
module branch_counter_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  frontend_pkg::predecode_t predecode,
    input  logic                    resolve,
    input  frontend_pkg::resolve_t  resolve_info,
    output logic                    predict_taken
);
    import frontend_pkg::*;

    // one 2-bit counter per index
    logic [1:0] ctr_q [COUNTER_ENTRIES];

    // counter under training and its next value
    logic [1:0] ctr_res;
    logic [1:0] ctr_res_next;

    // counter at the head bundle index
    logic [1:0] ctr_head;

    assign ctr_res = ctr_q[resolve_info.index];
    assign ctr_head = ctr_q[predecode.index];

    // saturating step
    always_comb begin
        if (resolve_info.taken) begin
            ctr_res_next = (ctr_res == CTR_MAX) ? CTR_MAX : ctr_res + 2'd1;
        end else begin
            ctr_res_next = (ctr_res == CTR_MIN) ? CTR_MIN : ctr_res - 2'd1;
        end
    end

    // table update
    // all counters start weakly not-taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < COUNTER_ENTRIES; i++) begin
                ctr_q[i] <= CTR_WEAK_NT;
            end
        end else if (resolve) begin
            ctr_q[resolve_info.index] <= ctr_res_next;
        end
    end

    // direction per bundle class
    always_comb begin
        case (predecode.bundle_btype)
            UNCOND: begin
                predict_taken = 1'b1;
            end
            INDIRECT: begin
                predict_taken = 1'b1;
            end
            PCREL: begin
                // msb of the counter is the taken guess
                predict_taken = ctr_head[1];
            end
            default: begin
                predict_taken = 1'b0;
            end
        endcase
    end

    // saturated counter must not wrap to strongly not-taken
    a_sat_high : assert property (
        @(posedge clk) disable iff (!rst_n)
        (resolve && resolve_info.taken && (ctr_res == CTR_MAX))
        |=> (ctr_q[$past(resolve_info.index)] == CTR_MAX)
    ) else $error("branch_counter_table: counter wrapped above 11");

    // and not wrap upward from the bottom
    a_sat_low : assert property (
        @(posedge clk) disable iff (!rst_n)
        (resolve && !resolve_info.taken && (ctr_res == CTR_MIN))
        |=> (ctr_q[$past(resolve_info.index)] == CTR_MIN)
    ) else $error("branch_counter_table: counter wrapped below 00");

endmodule

//--- hw/fetch_frontend.sv
module fetch_frontend (
    input  logic                       clk,
    input  logic                       rst_n,
    // fetch stage side
    input  logic                       push,
    input  frontend_pkg::fetch_bundle_t push_bundle,
    // decode side
    input  logic                       pop,
    // branch unit training
    input  logic                       resolve,
    input  frontend_pkg::resolve_t     resolve_info,
    // back-pressure to fetch
    output logic                       full,
    // head of the queue plus its predecode and prediction
    output logic                       out_valid,
    output frontend_pkg::fetch_bundle_t out_bundle,
    output frontend_pkg::predecode_t   out_predecode,
    output logic                       predict_taken
);
    import frontend_pkg::*;

    // head bundle from the queue
    fetch_bundle_t head_bundle;
    // classification of the head
    predecode_t head_predecode;

    // bundle buffer between fetch and decode
    fetch_queue i_fetch_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_bundle (push_bundle),
        .pop         (pop),
        .head_bundle (head_bundle),
        .head_valid  (out_valid),
        .full        (full)
    );

    // classify the head bundle
    fifo_predecoder i_fifo_predecoder (
        .head_bundle (head_bundle),
        .predecode   (head_predecode)
    );

    // direction prediction and training
    branch_counter_table i_branch_counter_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .predecode     (head_predecode),
        .resolve       (resolve),
        .resolve_info  (resolve_info),
        .predict_taken (predict_taken)
    );

    assign out_bundle = head_bundle;
    assign out_predecode = head_predecode;

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 5;

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset low for 5 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb/tb_fetch_frontend.sv
module tb_fetch_frontend;
    timeunit 1ns;
    timeprecision 100ps;
    import frontend_pkg::*;

    // phase lengths in cycles
    localparam int RESET_LEN = 5;
    localparam int BOOT_LEN = 10;
    localparam int TRAFFIC_LEN = 400;
    localparam int TRAIN_LEN = 300;
    localparam int SIMUL_LEN = 40;
    localparam int DRAIN_LEN = QUEUE_DEPTH + 4;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_LEN + BOOT_LEN + TRAFFIC_LEN + TRAIN_LEN + SIMUL_LEN + DRAIN_LEN) + 100;

    logic clk;
    logic rst_n;
    logic push;
    fetch_bundle_t push_bundle;
    logic pop;
    logic resolve;
    resolve_t resolve_info;
    logic full;
    logic out_valid;
    fetch_bundle_t out_bundle;
    predecode_t out_predecode;
    logic predict_taken;

    // reference state
    fetch_bundle_t model_q[$];
    logic [1:0] model_ctr [1 << PC_INDEX_WIDTH];
    int unsigned cycle_count;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_frontend i_fetch_frontend (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_bundle   (push_bundle),
        .pop           (pop),
        .resolve       (resolve),
        .resolve_info  (resolve_info),
        .full          (full),
        .out_valid     (out_valid),
        .out_bundle    (out_bundle),
        .out_predecode (out_predecode),
        .predict_taken (predict_taken)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bundle(input string name, input fetch_bundle_t act,
                                input fetch_bundle_t exp);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            stop_with_failure("head bundle differs from the reference queue");
        end
    endtask

    task automatic check_predecode(input string name, input predecode_t act,
                                   input predecode_t exp);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            stop_with_failure("predecode differs from the reference decoder");
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
            stop_with_failure("prediction differs from the reference counters");
        end
    endtask

    // slot class, priority indirect > unconditional > pc-relative
    function automatic btype_e ref_class(input logic [31:0] w);
        if (w[31:26] == 6'b010011) return INDIRECT;
        if (w[31:27] == 5'b01010 || w[31:27] == 5'b01001) return UNCOND;
        if (w[31:27] == 5'b01011 || w[31:28] == 4'b0110) return PCREL;
        return NONE;
    endfunction

    function automatic predecode_t ref_predecode(input fetch_bundle_t b);
        predecode_t pd;
        pd.slot_btype[0] = ref_class(b.inst0);
        pd.slot_btype[1] = ref_class(b.inst1);
        if (pd.slot_btype[1] != NONE) begin
            pd.bundle_btype = pd.slot_btype[1];
        end else if (b.pc[2]) begin
            // slot 0 lies before the fetch pc
            pd.bundle_btype = NONE;
        end else if (pd.slot_btype[0] == INDIRECT) begin
            pd.bundle_btype = INDIRECT;
        end else begin
            pd.bundle_btype = NONE;
        end
        pd.index = b.pc[PC_INDEX_WIDTH+2:3];
        return pd;
    endfunction

    function automatic logic ref_predict(input predecode_t pd);
        case (pd.bundle_btype)
            UNCOND, INDIRECT: return 1'b1;
            PCREL: return model_ctr[pd.index][1];
            default: return 1'b0;
        endcase
    endfunction

    // biased word, every opcode pattern shows up often
    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        int unsigned sel;
        w = $urandom;
        sel = $urandom_range(7);
        case (sel)
            0: w[31:27] = 5'b01010;
            1: w[31:27] = 5'b01001;
            2: w[31:27] = 5'b01011;
            3: w[31:28] = 4'b0110;
            4: w[31:26] = 6'b010011;
            default: ;
        endcase
        return w;
    endfunction

    // pc index kept to 16 entries so training hits later heads
    function automatic fetch_bundle_t random_bundle();
        fetch_bundle_t b;
        b.pc = $urandom;
        b.pc[PC_INDEX_WIDTH+2:3] = PC_INDEX_WIDTH'($urandom_range(15));
        b.pc[1:0] = 2'b00;
        b.inst0 = random_inst();
        b.inst1 = random_inst();
        return b;
    endfunction

    // one cycle of legal random traffic, never push while full
    task automatic drive_traffic(input int push_pct, input int pop_pct, input int res_pct);
        int occ;
        occ = model_q.size();
        push = (occ < QUEUE_DEPTH) && ($urandom_range(99) < push_pct);
        push_bundle = random_bundle();
        pop = (occ > 0) && ($urandom_range(99) < pop_pct);
        resolve = ($urandom_range(99) < res_pct);
        resolve_info.index = PC_INDEX_WIDTH'($urandom_range(15));
        resolve_info.taken = 1'($urandom_range(1));
    endtask

    // compare against the model, then advance it by this edge
    always @(posedge clk) begin : compare_proc
        predecode_t exp_pd;
        int occ;
        occ = model_q.size();
        if (!rst_n) begin
            model_q.delete();
            for (int i = 0; i < (1 << PC_INDEX_WIDTH); i++) begin
                model_ctr[i] = 2'b01;
            end
        end else begin
            if (out_valid !== (occ != 0)) begin
                stop_with_failure($sformatf("out_valid is %b with %0d bundles queued",
                                            out_valid, occ));
            end
            if (full !== (occ == QUEUE_DEPTH)) begin
                stop_with_failure($sformatf("full is %b with %0d bundles queued", full, occ));
            end
            if (out_valid) begin
                exp_pd = ref_predecode(model_q[0]);
                check_bundle("out_bundle", out_bundle, model_q[0]);
                check_predecode("out_predecode", out_predecode, exp_pd);
                check_bit("predict_taken", predict_taken, ref_predict(exp_pd));
            end
            if (pop) begin
                if (occ == 0) stop_with_failure("testbench popped an empty queue");
                void'(model_q.pop_front());
            end
            if (push) begin
                if (occ == QUEUE_DEPTH) stop_with_failure("testbench pushed a full queue");
                model_q.push_back(push_bundle);
            end
            // saturating counter step
            if (resolve) begin
                if (resolve_info.taken && model_ctr[resolve_info.index] != 2'b11) begin
                    model_ctr[resolve_info.index] = model_ctr[resolve_info.index] + 2'd1;
                end else if (!resolve_info.taken && model_ctr[resolve_info.index] != 2'b00) begin
                    model_ctr[resolve_info.index] = model_ctr[resolve_info.index] - 2'd1;
                end
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_with_failure("timeout: run did not finish within the cycle limit");
        end
    end

    initial begin
        int idx;
        int run_len;
        int train_cycles;
        logic taken;
        predecode_t head_pd;
        void'($urandom(32'h3e4b_ddd5));
        cycle_count = 0;
        push = 1'b0;
        push_bundle = '0;
        pop = 1'b0;
        resolve = 1'b0;
        resolve_info = '0;
        wait (rst_n === 1'b1);
        @(negedge clk);

        // reset state, then a pc-relative bundle on a fresh counter
        if (out_valid !== 1'b0 || full !== 1'b0) begin
            stop_with_failure("out_valid or full is high right after reset");
        end
        push = 1'b1;
        push_bundle.pc = 32'h0000_0010;
        push_bundle.inst0 = 32'h0000_0000;
        push_bundle.inst1 = 32'h5800_0000;
        @(negedge clk);
        push = 1'b0;
        while (!out_valid) @(negedge clk);
        check_bit("predict_taken", predict_taken, 1'b0);
        pop = 1'b1;
        @(negedge clk);
        pop = 1'b0;
        repeat (BOOT_LEN - 3) @(negedge clk);

        // alternating fill-heavy and drain-heavy traffic
        for (int i = 0; i < TRAFFIC_LEN; i++) begin
            if ((i / 40) % 2 == 0) drive_traffic(80, 30, 20);
            else drive_traffic(30, 80, 20);
            @(negedge clk);
        end

        // runs of one outcome on one index, reaching saturation
        train_cycles = 0;
        while (train_cycles < TRAIN_LEN) begin
            idx = $urandom_range(15);
            taken = 1'($urandom_range(1));
            run_len = $urandom_range(1, 6);
            repeat (run_len) begin
                drive_traffic(50, 50, 0);
                resolve = 1'b1;
                resolve_info.index = PC_INDEX_WIDTH'(idx);
                resolve_info.taken = taken;
                @(negedge clk);
            end
            train_cycles += run_len;
        end
        push = 1'b0;
        resolve = 1'b0;

        // empty the queue, then a pc-relative head at index 5
        pop = 1'b1;
        while (model_q.size() != 0) @(negedge clk);
        pop = 1'b0;
        push = 1'b1;
        push_bundle.pc = 32'h0000_0028;
        push_bundle.inst0 = 32'h0000_0000;
        push_bundle.inst1 = 32'h5800_0000;
        @(negedge clk);
        push = 1'b0;

        // train the head index, each edge visible at the next compare
        head_pd = ref_predecode(model_q[0]);
        resolve = 1'b1;
        resolve_info.index = head_pd.index;
        resolve_info.taken = 1'b1;
        repeat (3) @(negedge clk);
        resolve = 1'b0;
        check_bit("predict_taken", predict_taken, 1'b1);

        // push and pop on the same edge keep one entry
        for (int i = 0; i < SIMUL_LEN / 2; i++) begin
            push = 1'b1;
            pop = 1'b1;
            push_bundle = random_bundle();
            @(negedge clk);
        end
        push = 1'b0;

        // drain
        while (model_q.size() != 0) @(negedge clk);
        pop = 1'b0;
        repeat (2) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- sim.f
hw/frontend_pkg.sv
hw/fetch_queue.sv
hw/fifo_predecoder.sv
hw/branch_counter_table.sv
hw/fetch_frontend.sv
tb/tb_clock_gen.sv
tb/tb_fetch_frontend.sv

//--- run.sh
#!/bin/sh
# compile with verilator and run the testbench
# exit status is nonzero when the build or the run fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_fetch_frontend \
    -Mdir obj_dir \
    -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_fetch_frontend
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
